//--- Makefile
VERILATOR ?= verilator
TOP       := rv_core_tb
RTL_TOP   := rv_core
FILELIST  := build.f
VFLAGS    := --timing
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
common/rv_isa_pkg.sv
common/rv_ctrl_pkg.sv
fetch/instr_fetch.sv
decode/instr_decoder.sv
decode/imm_gen.sv
execute/reg_file.sv
execute/alu.sv
design/retire_stage.sv
design/rv_core.sv
test/clk_gen.sv
test/rv_core_tb.sv

//--- common/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

	// alu function, {instr[30], funct3} style code
	typedef logic [3:0] alu_fn_t;

	localparam alu_fn_t ALU_ADD  = 4'b0000;	// add, addi, jalr target
	localparam alu_fn_t ALU_SLL  = 4'b0001;
	localparam alu_fn_t ALU_SLT  = 4'b0010;	// also blt
	localparam alu_fn_t ALU_SLTU = 4'b0011;	// also bltu
	localparam alu_fn_t ALU_XOR  = 4'b0100;
	localparam alu_fn_t ALU_SRL  = 4'b0101;
	localparam alu_fn_t ALU_OR   = 4'b0110;
	localparam alu_fn_t ALU_AND  = 4'b0111;
	localparam alu_fn_t ALU_SUB  = 4'b1000;	// also beq / bne
	localparam alu_fn_t ALU_BGE  = 4'b1001;
	localparam alu_fn_t ALU_BGEU = 4'b1010;
	localparam alu_fn_t ALU_SRA  = 4'b1101;

	typedef logic [1:0] bsel_t;	// operand b source
	localparam bsel_t BSEL_RS2   = 2'b00;
	localparam bsel_t BSEL_IMM   = 2'b01;
	localparam bsel_t BSEL_SHAMT = 2'b10;	// imm[4:0] zero extended

	typedef logic [2:0] wb_sel_t;	// regfile write source
	localparam wb_sel_t WB_ALU  = 3'b000;
	localparam wb_sel_t WB_LINK = 3'b111;	// pc + 4 for jal / jalr

	typedef logic [1:0] pc_sel_t;
	localparam pc_sel_t PC_SEQ = 2'b00;	// pc + 4
	localparam pc_sel_t PC_BRJ = 2'b10;	// branch or jump, resolved in fetch

endpackage

`default_nettype wire

//--- common/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	typedef logic [31:0] xlen_t;	// data word
	typedef logic [31:0] instr_t;	// raw instruction
	typedef logic [4:0] reg_idx_t;	// x0..x31
	typedef logic [6:0] opcode_t;	// instr[6:0]
	typedef logic [2:0] funct3_t;	// instr[14:12]

	// major opcodes handled by the core
	localparam opcode_t OP_RTYPE  = 7'b0110011;
	localparam opcode_t OP_ITYPE  = 7'b0010011;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;

	// alu ops, r and i forms share these
	localparam funct3_t F3_ADD_SUB = 3'b000;
	localparam funct3_t F3_SLL     = 3'b001;
	localparam funct3_t F3_SLT     = 3'b010;
	localparam funct3_t F3_SLTU    = 3'b011;
	localparam funct3_t F3_XOR     = 3'b100;
	localparam funct3_t F3_SRL_SRA = 3'b101;	// bit 30 picks sra
	localparam funct3_t F3_OR      = 3'b110;
	localparam funct3_t F3_AND     = 3'b111;

	// conditional branches
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	localparam funct3_t F3_JALR = 3'b000;	// only legal encoding

endpackage

`default_nettype wire

//--- decode/imm_gen.sv
`timescale 1ns/10ps
`default_nettype none

module imm_gen
	import rv_isa_pkg::*;
(
	input wire instr_t i_instr,
	output xlen_t o_imm	// sign extended
);

	opcode_t op;
	xlen_t imm_i, imm_b, imm_j;

	assign op = i_instr[6:0];

	// i format, also jalr and shift amounts
	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};

	// b format, offset in halfwords
	assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
		i_instr[11:8], 1'b0};

	// j format
	assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
		i_instr[30:21], 1'b0};

	always_comb begin
		case (op)
			OP_BRANCH: o_imm = imm_b;
			OP_JAL:    o_imm = imm_j;
			default:   o_imm = imm_i;	// itype, jalr, don't care for rtype
		endcase
	end

endmodule

`default_nettype wire

//--- decode/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;
(
	input wire opcode_t i_op,
	input wire funct3_t i_funct3,
	input wire logic i_instr_30,	// funct7 bit 5, sub / sra select
	output pc_sel_t o_pc_sel,
	output logic o_we,		// regfile write
	output bsel_t o_b_sel,
	output alu_fn_t o_alu_fn,
	output wb_sel_t o_wb_sel,
	output logic o_bneq,
	output logic o_btype,
	output logic o_j,
	output logic o_jr
);

	logic rtype, itype, btype, jtype, jrtype;
	logic op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl, op_sra, op_or, op_and;
	logic op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi, op_slli, op_srli, op_srai;
	logic op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu;
	logic op_jal, op_jalr;
	logic alu_r, alu_i;	// any legal r / i op

	// instruction class
	assign rtype  = (i_op == OP_RTYPE);
	assign itype  = (i_op == OP_ITYPE);
	assign btype  = (i_op == OP_BRANCH);
	assign jtype  = (i_op == OP_JAL);
	assign jrtype = (i_op == OP_JALR);

	// r type, bit 30 splits add/sub and srl/sra
	assign op_add  = rtype & ~i_instr_30 & (i_funct3 == F3_ADD_SUB);
	assign op_sub  = rtype &  i_instr_30 & (i_funct3 == F3_ADD_SUB);
	assign op_sll  = rtype & ~i_instr_30 & (i_funct3 == F3_SLL);
	assign op_slt  = rtype & ~i_instr_30 & (i_funct3 == F3_SLT);
	assign op_sltu = rtype & ~i_instr_30 & (i_funct3 == F3_SLTU);
	assign op_xor  = rtype & ~i_instr_30 & (i_funct3 == F3_XOR);
	assign op_srl  = rtype & ~i_instr_30 & (i_funct3 == F3_SRL_SRA);
	assign op_sra  = rtype &  i_instr_30 & (i_funct3 == F3_SRL_SRA);
	assign op_or   = rtype & ~i_instr_30 & (i_funct3 == F3_OR);
	assign op_and  = rtype & ~i_instr_30 & (i_funct3 == F3_AND);

	// i type, bit 30 is immediate data except for shifts
	assign op_addi  = itype & (i_funct3 == F3_ADD_SUB);
	assign op_slti  = itype & (i_funct3 == F3_SLT);
	assign op_sltiu = itype & (i_funct3 == F3_SLTU);
	assign op_xori  = itype & (i_funct3 == F3_XOR);
	assign op_ori   = itype & (i_funct3 == F3_OR);
	assign op_andi  = itype & (i_funct3 == F3_AND);
	assign op_slli  = itype & ~i_instr_30 & (i_funct3 == F3_SLL);
	assign op_srli  = itype & ~i_instr_30 & (i_funct3 == F3_SRL_SRA);
	assign op_srai  = itype &  i_instr_30 & (i_funct3 == F3_SRL_SRA);

	// branches, 010 and 011 are not defined
	assign op_beq  = btype & (i_funct3 == F3_BEQ);
	assign op_bne  = btype & (i_funct3 == F3_BNE);
	assign op_blt  = btype & (i_funct3 == F3_BLT);
	assign op_bge  = btype & (i_funct3 == F3_BGE);
	assign op_bltu = btype & (i_funct3 == F3_BLTU);
	assign op_bgeu = btype & (i_funct3 == F3_BGEU);

	assign op_jal  = jtype;
	assign op_jalr = jrtype & (i_funct3 == F3_JALR);

	assign alu_r = op_add | op_sub | op_sll | op_slt | op_sltu | op_xor |
		op_srl | op_sra | op_or | op_and;
	assign alu_i = op_addi | op_slti | op_sltiu | op_xori | op_ori | op_andi |
		op_slli | op_srli | op_srai;

	// pc select: 00 sequential, 10 branch/jump, bit 0 unused
	assign o_pc_sel[0] = 1'b0;
	assign o_pc_sel[1] = op_beq | op_bne | op_blt | op_bge | op_bltu | op_bgeu | op_jal | op_jalr;

	assign o_we = alu_r | alu_i | op_jal | op_jalr;	// branches and unknowns never write

	assign o_b_sel[0] = op_addi | op_slti | op_sltiu | op_xori | op_ori | op_andi | op_jalr;
	assign o_b_sel[1] = op_slli | op_srli | op_srai;	// shamt path

	// alu code bits, branches reuse the compare codes
	assign o_alu_fn[0] = op_sll | op_slli | op_sltu | op_sltiu | op_srl | op_srli |
		op_and | op_andi | op_sra | op_srai | op_bltu | op_bge;
	assign o_alu_fn[1] = op_slt | op_slti | op_sltu | op_sltiu | op_or | op_ori |
		op_and | op_andi | op_blt | op_bltu | op_bgeu;
	assign o_alu_fn[2] = op_xor | op_xori | op_srl | op_srli | op_or | op_ori |
		op_and | op_andi | op_sra | op_srai;
	assign o_alu_fn[3] = op_sub | op_sra | op_srai | op_beq | op_bne | op_bge | op_bgeu;	// jalr -> add

	assign o_bneq  = op_bne;
	assign o_btype = btype;
	assign o_j     = op_jal;
	assign o_jr    = op_jalr;

	// link for anything outside r/i, only matters when o_we is set
	assign o_wb_sel[0] = ~(rtype | itype) | op_jal | op_jalr;
	assign o_wb_sel[1] = ~(rtype | itype);
	assign o_wb_sel[2] = ~(rtype | itype);

endmodule

`default_nettype wire

//--- design/retire_stage.sv
`timescale 1ns/10ps
`default_nettype none

module retire_stage
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;
#(
	parameter xlen_t RESET_PC = '0
) (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_we,
	input wire wb_sel_t i_wb_sel,
	input wire reg_idx_t i_rd,
	input wire xlen_t i_alu_result,
	input wire xlen_t i_pc_plus4,	// link value
	input wire xlen_t i_pc,
	output logic o_rf_we,
	output xlen_t o_rf_wdata,
	output logic o_retire_valid,
	output xlen_t o_retire_pc,
	output logic o_rd_we,
	output reg_idx_t o_rd_addr,
	output xlen_t o_rd_data
);

	always_comb begin
		case (i_wb_sel)
			WB_LINK: o_rf_wdata = i_pc_plus4;
			WB_ALU:  o_rf_wdata = i_alu_result;
			default: o_rf_wdata = i_alu_result;
		endcase
	end

	assign o_rf_we = i_we & (i_rd != '0);	// x0 is never written

	// report trails the fetch by one cycle
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_retire_valid <= 1'b0;
			o_retire_pc <= RESET_PC;
			o_rd_we <= 1'b0;
		end else begin
			o_retire_valid <= 1'b1;	// one retire per cycle, never stalls
			o_retire_pc <= i_pc;
			o_rd_we <= o_rf_we;
		end
	end

	// payload, qualified by o_rd_we
	always_ff @(posedge i_clk) begin
		o_rd_addr <= i_rd;
		o_rd_data <= o_rf_wdata;
	end

endmodule

`default_nettype wire

//--- design/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;
#(
	parameter xlen_t RESET_PC = '0,
	parameter int IMEM_AW = 8
) (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire instr_t i_imem_data,	// combinational rom return
	output logic [IMEM_AW-1:0] o_imem_addr,
	output logic o_retire_valid,
	output xlen_t o_retire_pc,
	output logic o_rd_we,
	output reg_idx_t o_rd_addr,
	output xlen_t o_rd_data
);

	instr_t instr;
	pc_sel_t pc_sel;
	bsel_t b_sel;
	alu_fn_t alu_fn;
	wb_sel_t wb_sel;
	logic we, bneq, btype, j, jr, cond, rf_we;
	xlen_t pc, pc_plus4, imm, rs1_data, rs2_data, alu_result, rf_wdata;

	assign instr = i_imem_data;

	instr_fetch #(.RESET_PC(RESET_PC), .IMEM_AW(IMEM_AW)) u_fetch (
		.i_clk(i_clk), .i_rst(i_rst), .i_pc_sel(pc_sel),
		.i_btype(btype), .i_bneq(bneq), .i_j(j), .i_jr(jr), .i_cond(cond),
		.i_imm(imm), .i_jalr_target(alu_result),
		.o_pc(pc), .o_pc_plus4(pc_plus4), .o_imem_addr(o_imem_addr)
	);

	instr_decoder u_dec (
		.i_op(instr[6:0]), .i_funct3(instr[14:12]), .i_instr_30(instr[30]),
		.o_pc_sel(pc_sel), .o_we(we), .o_b_sel(b_sel), .o_alu_fn(alu_fn),
		.o_wb_sel(wb_sel), .o_bneq(bneq), .o_btype(btype), .o_j(j), .o_jr(jr)
	);

	imm_gen u_imm (.i_instr(instr), .o_imm(imm));

	reg_file u_rf (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_rs1(instr[19:15]), .i_rs2(instr[24:20]),
		.i_we(rf_we), .i_rd(instr[11:7]), .i_wdata(rf_wdata),
		.o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
	);

	alu u_alu (
		.i_fn(alu_fn), .i_b_sel(b_sel), .i_a(rs1_data), .i_rs2(rs2_data), .i_imm(imm),
		.o_result(alu_result), .o_cond(cond)
	);

	retire_stage #(.RESET_PC(RESET_PC)) u_retire (
		.i_clk(i_clk), .i_rst(i_rst), .i_we(we), .i_wb_sel(wb_sel), .i_rd(instr[11:7]),
		.i_alu_result(alu_result), .i_pc_plus4(pc_plus4), .i_pc(pc),
		.o_rf_we(rf_we), .o_rf_wdata(rf_wdata),
		.o_retire_valid(o_retire_valid), .o_retire_pc(o_retire_pc),
		.o_rd_we(o_rd_we), .o_rd_addr(o_rd_addr), .o_rd_data(o_rd_data)
	);

endmodule

`default_nettype wire

//--- execute/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;
(
	input wire alu_fn_t i_fn,
	input wire bsel_t i_b_sel,
	input wire xlen_t i_a,		// rs1
	input wire xlen_t i_rs2,
	input wire xlen_t i_imm,
	output xlen_t o_result,
	output logic o_cond		// branch condition for compare codes
);

	xlen_t op_b;
	xlen_t diff;
	logic [4:0] shamt;
	logic lt_s, lt_u;

	always_comb begin
		case (i_b_sel)
			BSEL_IMM:   op_b = i_imm;
			BSEL_SHAMT: op_b = {27'd0, i_imm[4:0]};	// upper imm bits carry srai flag
			default:    op_b = i_rs2;
		endcase
	end

	assign shamt = op_b[4:0];
	assign diff = i_a - op_b;
	assign lt_s = $signed(i_a) < $signed(op_b);
	assign lt_u = i_a < op_b;

	always_comb begin
		case (i_fn)
			ALU_ADD:  o_result = i_a + op_b;
			ALU_SUB:  o_result = diff;
			ALU_SLL:  o_result = i_a << shamt;
			ALU_SLT:  o_result = {31'd0, lt_s};
			ALU_SLTU: o_result = {31'd0, lt_u};
			ALU_XOR:  o_result = i_a ^ op_b;
			ALU_SRL:  o_result = i_a >> shamt;
			ALU_SRA:  o_result = xlen_t'($signed(i_a) >>> shamt);	// sign fill
			ALU_OR:   o_result = i_a | op_b;
			ALU_AND:  o_result = i_a & op_b;
			ALU_BGE:  o_result = {31'd0, ~lt_s};	// compare only, no writeback
			ALU_BGEU: o_result = {31'd0, ~lt_u};
			default:  o_result = '0;
		endcase
	end

	// beq/bne look at zero, bne inverts in fetch
	always_comb begin
		case (i_fn)
			ALU_SUB:  o_cond = (diff == '0);
			ALU_SLT:  o_cond = lt_s;
			ALU_SLTU: o_cond = lt_u;
			ALU_BGE:  o_cond = ~lt_s;
			ALU_BGEU: o_cond = ~lt_u;
			default:  o_cond = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- execute/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file
	import rv_isa_pkg::*;
(
	input wire logic i_clk,
	input wire logic i_rst,
	input wire reg_idx_t i_rs1,
	input wire reg_idx_t i_rs2,
	input wire logic i_we,		// already gated for x0
	input wire reg_idx_t i_rd,
	input wire xlen_t i_wdata,
	output xlen_t o_rs1_data,
	output xlen_t o_rs2_data
);

	xlen_t regs [0:31];

	// write on the edge closing the fetch cycle
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int k = 0; k < 32; k++)
				regs[k] <= '0;	// x0 stays zero from here on
		end else if (i_we) begin
			regs[i_rd] <= i_wdata;
		end
	end

	// async reads, no write bypass needed in a single cycle core
	assign o_rs1_data = regs[i_rs1];
	assign o_rs2_data = regs[i_rs2];

endmodule

`default_nettype wire

//--- fetch/instr_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module instr_fetch
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;
#(
	parameter xlen_t RESET_PC = '0,
	parameter int IMEM_AW = 8	// rom byte address width
) (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire pc_sel_t i_pc_sel,
	input wire logic i_btype,	// conditional branch
	input wire logic i_bneq,	// invert condition (bne)
	input wire logic i_j,		// jal
	input wire logic i_jr,		// jalr
	input wire logic i_cond,	// alu compare outcome
	input wire xlen_t i_imm,	// branch / jal offset
	input wire xlen_t i_jalr_target,	// rs1 + imm from alu
	output xlen_t o_pc,
	output xlen_t o_pc_plus4,
	output logic [IMEM_AW-1:0] o_imem_addr
);

	xlen_t pc;
	xlen_t pc_imm;	// pc relative target
	xlen_t pc_next;
	logic taken;

	assign o_pc_plus4 = pc + xlen_t'(4);
	assign pc_imm = pc + i_imm;

	// beq/blt/bge style take on cond, bne takes on !cond
	assign taken = i_btype & (i_cond ^ i_bneq);

	always_comb begin
		pc_next = o_pc_plus4;	// default sequential
		case (i_pc_sel)
			PC_BRJ: begin
				if (i_jr)
					pc_next = {i_jalr_target[31:1], 1'b0};	// lsb cleared
				else if (i_j | taken)
					pc_next = pc_imm;
			end
			default: pc_next = o_pc_plus4;
		endcase
	end

	// pc moves on the same edge as the regfile write
	always_ff @(posedge i_clk) begin
		if (i_rst)
			pc <= RESET_PC;
		else
			pc <= pc_next;
	end

	assign o_pc = pc;
	assign o_imem_addr = pc[IMEM_AW-1:0];	// rom sees low byte address bits

endmodule

`default_nettype wire

//--- test/clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
	parameter int HALF_PERIOD = 5,	// 10 ns clock
	parameter int RESET_CYCLES = 5
) (
	output logic o_clk,
	output logic o_rst		// sync, active high
);

	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	// held over the first rising edges, released on an edge
	initial begin
		o_rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_rst <= 1'b0;
	end

endmodule

`default_nettype wire

//--- test/rv_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb
	import rv_isa_pkg::*;
();

	localparam xlen_t RESET_PC = 32'h0000_0000;
	localparam int IMEM_AW = 8;
	localparam int ROM_WORDS = 2 ** (IMEM_AW - 2);
	localparam int RESET_CYCLES = 5;
	localparam int MAX_ROWS = 64;

	logic clk, rst;
	instr_t imem_data;
	logic [IMEM_AW-1:0] imem_addr;
	logic o_retire_valid, o_rd_we;
	xlen_t o_retire_pc, o_rd_data;
	reg_idx_t o_rd_addr;

	// program table, rows in retire order
	instr_t tab_instr [0:MAX_ROWS-1];
	xlen_t tab_pc [0:MAX_ROWS-1];
	logic tab_we [0:MAX_ROWS-1];
	reg_idx_t tab_rd [0:MAX_ROWS-1];
	xlen_t tab_data [0:MAX_ROWS-1];
	instr_t rom [0:ROM_WORDS-1];
	int nrows = 0;
	int row = 0;
	int cycles = 0;
	int timeout_limit = 0;

	clk_gen #(.HALF_PERIOD(5), .RESET_CYCLES(RESET_CYCLES)) u_clk (.o_clk(clk), .o_rst(rst));

	rv_core #(.RESET_PC(RESET_PC), .IMEM_AW(IMEM_AW)) uut (
		.i_clk(clk), .i_rst(rst), .i_imem_data(imem_data),
		.o_imem_addr(imem_addr), .o_retire_valid(o_retire_valid),
		.o_retire_pc(o_retire_pc), .o_rd_we(o_rd_we),
		.o_rd_addr(o_rd_addr), .o_rd_data(o_rd_data)
	);

	assign imem_data = rom[imem_addr[IMEM_AW-1:2]];	// same cycle rom return

	// instruction encoders
	function automatic instr_t enc_r(input logic alt, input reg_idx_t rs2, input reg_idx_t rs1,
		input funct3_t f3, input reg_idx_t rd);
		enc_r = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, OP_RTYPE};	// alt = sub / sra
	endfunction

	function automatic instr_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
		input funct3_t f3, input reg_idx_t rd, input opcode_t op);
		enc_i = {imm, rs1, f3, rd, op};
	endfunction

	function automatic instr_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
		input reg_idx_t rs1, input funct3_t f3);
		enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic instr_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
		enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	task automatic add_row(input instr_t ins, input xlen_t pc, input logic we,
		input reg_idx_t rd, input xlen_t data);
		tab_instr[nrows] = ins;
		tab_pc[nrows] = pc;
		tab_we[nrows] = we;
		tab_rd[nrows] = rd;
		tab_data[nrows] = data;
		nrows++;
	endtask

	task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s: got 0x%08h expected 0x%08h", $time, name, got, exp);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s: got x%0d expected x%0d", $time, name, got, exp);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s: got %b expected %b", $time, name, got, exp);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	// run limit, counts every edge from time 0
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_limit) begin
			$display("timeout: retire %0d of %0d not seen after %0d cycles", row, nrows, cycles);
			$display("Simulation FAILED");
			$fatal(1);
		end
	end

	initial begin
		// x1 = -5, x2 = 3 feed the alu rows
		add_row(enc_i(12'hFFB, 5'd0, F3_ADD_SUB, 5'd1, OP_ITYPE), 32'h00, 1'b1, 5'd1, 32'hFFFF_FFFB);
		add_row(enc_i(12'h003, 5'd0, F3_ADD_SUB, 5'd2, OP_ITYPE), 32'h04, 1'b1, 5'd2, 32'h3);
		add_row(enc_r(1'b0, 5'd2, 5'd1, F3_ADD_SUB, 5'd3), 32'h08, 1'b1, 5'd3, 32'hFFFF_FFFE);
		add_row(enc_r(1'b1, 5'd1, 5'd2, F3_ADD_SUB, 5'd4), 32'h0C, 1'b1, 5'd4, 32'h8);	// 3 - -5
		add_row(enc_r(1'b1, 5'd2, 5'd1, F3_SRL_SRA, 5'd5), 32'h10, 1'b1, 5'd5, 32'hFFFF_FFFF);
		add_row(enc_r(1'b0, 5'd2, 5'd1, F3_SRL_SRA, 5'd6), 32'h14, 1'b1, 5'd6, 32'h1FFF_FFFF);
		add_row(enc_r(1'b0, 5'd2, 5'd2, F3_SLL, 5'd7), 32'h18, 1'b1, 5'd7, 32'h18);
		add_row(enc_r(1'b0, 5'd2, 5'd1, F3_SLT, 5'd8), 32'h1C, 1'b1, 5'd8, 32'h1);	// signed
		add_row(enc_r(1'b0, 5'd2, 5'd1, F3_SLTU, 5'd9), 32'h20, 1'b1, 5'd9, 32'h0);	// unsigned
		add_row(enc_r(1'b0, 5'd2, 5'd1, F3_XOR, 5'd10), 32'h24, 1'b1, 5'd10, 32'hFFFF_FFF8);
		add_row(enc_r(1'b0, 5'd2, 5'd1, F3_OR, 5'd11), 32'h28, 1'b1, 5'd11, 32'hFFFF_FFFB);
		add_row(enc_r(1'b0, 5'd2, 5'd1, F3_AND, 5'd12), 32'h2C, 1'b1, 5'd12, 32'h3);
		add_row(enc_i(12'hFFF, 5'd2, F3_SLTU, 5'd13, OP_ITYPE), 32'h30, 1'b1, 5'd13, 32'h1);
		add_row(enc_i(12'h0F0, 5'd1, F3_XOR, 5'd14, OP_ITYPE), 32'h34, 1'b1, 5'd14, 32'hFFFF_FF0B);
		add_row(enc_i(12'h004, 5'd2, F3_SLL, 5'd15, OP_ITYPE), 32'h38, 1'b1, 5'd15, 32'h30);
		add_row(enc_i(12'h01C, 5'd1, F3_SRL_SRA, 5'd16, OP_ITYPE), 32'h3C, 1'b1, 5'd16, 32'hF);
		add_row(enc_i(12'h401, 5'd1, F3_SRL_SRA, 5'd17, OP_ITYPE), 32'h40, 1'b1, 5'd17, 32'hFFFF_FFFD);
		add_row(enc_i(12'h007, 5'd1, F3_ADD_SUB, 5'd0, OP_ITYPE), 32'h44, 1'b0, 5'd0, 32'h0);	// x0
		add_row(enc_r(1'b0, 5'd2, 5'd0, F3_ADD_SUB, 5'd18), 32'h48, 1'b1, 5'd18, 32'h3);	// x0 reads 0
		add_row(32'h0000_0000, 32'h4C, 1'b0, 5'd0, 32'h0);	// unknown opcode, no-op
		// branches, +8 skips one slot when taken
		add_row(enc_b(13'd8, 5'd12, 5'd2, F3_BEQ), 32'h50, 1'b0, 5'd0, 32'h0);	// taken
		add_row(enc_b(13'd8, 5'd2, 5'd1, F3_BEQ), 32'h58, 1'b0, 5'd0, 32'h0);
		add_row(enc_b(13'd8, 5'd2, 5'd1, F3_BNE), 32'h5C, 1'b0, 5'd0, 32'h0);	// taken
		add_row(enc_b(13'd8, 5'd12, 5'd2, F3_BNE), 32'h64, 1'b0, 5'd0, 32'h0);
		add_row(enc_b(13'd8, 5'd2, 5'd1, F3_BLT), 32'h68, 1'b0, 5'd0, 32'h0);	// taken
		add_row(enc_b(13'd8, 5'd1, 5'd2, F3_BLT), 32'h70, 1'b0, 5'd0, 32'h0);
		add_row(enc_b(13'd8, 5'd1, 5'd2, F3_BLTU), 32'h74, 1'b0, 5'd0, 32'h0);	// taken
		add_row(enc_b(13'd8, 5'd2, 5'd1, F3_BLTU), 32'h7C, 1'b0, 5'd0, 32'h0);
		add_row(enc_b(13'd8, 5'd1, 5'd2, F3_BGE), 32'h80, 1'b0, 5'd0, 32'h0);	// taken
		add_row(enc_b(13'd8, 5'd2, 5'd1, F3_BGE), 32'h88, 1'b0, 5'd0, 32'h0);
		add_row(enc_b(13'd8, 5'd2, 5'd1, F3_BGEU), 32'h8C, 1'b0, 5'd0, 32'h0);	// taken
		add_row(enc_b(13'd8, 5'd1, 5'd2, F3_BGEU), 32'h94, 1'b0, 5'd0, 32'h0);
		// jumps and links
		add_row(enc_j(21'd12, 5'd19), 32'h98, 1'b1, 5'd19, 32'h9C);
		add_row(enc_i(12'h0B0, 5'd0, F3_ADD_SUB, 5'd20, OP_ITYPE), 32'hA4, 1'b1, 5'd20, 32'hB0);
		add_row(enc_i(12'h005, 5'd20, F3_JALR, 5'd21, OP_JALR), 32'hA8, 1'b1, 5'd21, 32'hAC);	// 0xb5
		add_row(enc_j(21'd8, 5'd0), 32'hB4, 1'b0, 5'd0, 32'h0);	// link to x0 dropped
		add_row(enc_r(1'b0, 5'd21, 5'd19, F3_ADD_SUB, 5'd22), 32'hBC, 1'b1, 5'd22, 32'h148);

		// unused slots hold harmless x0 writes tagged with their word address
		for (int a = 0; a < ROM_WORDS; a++)
			rom[a] = {20'(a), 12'h013};
		for (int k = 0; k < nrows; k++)
			rom[tab_pc[k][IMEM_AW-1:2]] = tab_instr[k];
		timeout_limit = nrows + RESET_CYCLES + 10;

		@(negedge clk);
		while (rst)
			@(negedge clk);	// last reset edge has passed
		check_bit("o_retire_valid", o_retire_valid, 1'b0);
		check_bit("o_rd_we", o_rd_we, 1'b0);

		// first fetch is in this cycle, each retire lands one edge later
		for (row = 0; row < nrows; row++) begin
			@(negedge clk);
			check_bit("o_retire_valid", o_retire_valid, 1'b1);
			check_word("o_retire_pc", o_retire_pc, tab_pc[row]);
			check_bit("o_rd_we", o_rd_we, tab_we[row]);
			if (tab_we[row]) begin
				check_reg("o_rd_addr", o_rd_addr, tab_rd[row]);
				check_word("o_rd_data", o_rd_data, tab_data[row]);
			end
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire
